// ==== source/pm_wrapper_pkg.sv ====
/* command codes, sizes, FSM states and the sensor config word
   shared by the power-monitor wrapper */
package pm_wrapper_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  // three speed rings plus the rc ring
  parameter int NUM_SENSORS       = 4;
  parameter int CFG_BITS          = 8;
  parameter int SYNC_DEPTH_REQ    = 3;
  parameter int SYNC_DEPTH_SENSOR = 2;

  // host command as {shift_en, select_ctr}
  typedef enum logic [1:0] {
    CMD_DESELECT    = 2'b00,
    CMD_SELECT      = 2'b01,
    CMD_SHIFT_CFG   = 2'b10,
    CMD_SHIFT_COUNT = 2'b11
  } cmd_e;

  // wrapper FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_RUN  = 2'b01,
    ST_SAVE = 2'b11,
    ST_STOP = 2'b10
  } ctrl_state_e;

  // ------------------------------
  // sensor configuration word
  // ------------------------------
  // shifted in as a flat vector, read back as fields
  typedef union packed {
    logic [CFG_BITS-1:0] flat;
    struct packed {
      logic [1:0]             div_rc;
      logic [1:0]             div;
      logic [NUM_SENSORS-1:0] powerdown;
    } fields;
  } cfg_word_u;

endpackage

// ==== source/pm_cmd_if.sv ====
/* decoded host command and its completion pulses */
`timescale 1ns/10ps

interface pm_cmd_if;

  logic                     cmd_valid;
  pm_wrapper_pkg::cmd_e     cmd;
  logic                     serial_bit;
  // one done pulse per command, from its owner
  logic                     cfg_done;
  logic                     ctrl_done;

  modport decoder (
    output cmd_valid, cmd, serial_bit,
    input  cfg_done, ctrl_done
  );

  modport cfg (
    input  cmd_valid, cmd, serial_bit,
    output cfg_done
  );

  modport ctrl (
    input  cmd_valid, cmd,
    output ctrl_done
  );

endinterface

// ==== source/pm_count_if.sv ====
/* count enables, clear, busy flags and counts
   between the wrapper FSM and the ring counters */
`timescale 1ns/10ps

interface pm_count_if #(
  parameter int COUNTER_SIZE = 32
);

  logic [pm_wrapper_pkg::NUM_SENSORS-1:0] count_en;
  logic                                   clear;
  // busy is the counter side copy of count_en
  logic [pm_wrapper_pkg::NUM_SENSORS-1:0] busy;
  logic [COUNTER_SIZE-1:0]                count [pm_wrapper_pkg::NUM_SENSORS];

  modport ctrl (
    output count_en, clear,
    input  busy, count
  );

  modport counter (
    input  count_en, clear,
    output busy, count
  );

endinterface

// ==== source/pm_req_sync.sv ====
/* host request synchronizer, command capture and decode,
   ack generation for the req/ack link */
`timescale 1ns/10ps

module pm_req_sync (
  input  logic      rc_osc_i_after_mux,
  input  logic      pmbw_rstn,
  input  logic      pmbw_req_i,
  input  logic      serial_in_i,
  input  logic      shift_en_i,
  input  logic      select_ctr_i,
  output logic      pmbw_ack_o,
  pm_cmd_if.decoder cmd_bus
);

  localparam int DEPTH = pm_wrapper_pkg::SYNC_DEPTH_REQ;

  logic [DEPTH-1:0]     req_sync_q;
  logic                 req_sync;
  logic                 taken_q;
  logic                 ack_q;
  logic                 serial_q;
  pm_wrapper_pkg::cmd_e cmd_q;

  // ------------------------------
  // request synchronizer
  // ------------------------------
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[DEPTH-2:0], pmbw_req_i};
    end
  end

  assign req_sync = req_sync_q[DEPTH-1];

  // command inputs are steady while req is high,
  // capture one stage early so they are ready with req_sync
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      cmd_q    <= pm_wrapper_pkg::CMD_DESELECT;
      serial_q <= 1'b0;
    end else if (req_sync_q[DEPTH-2]) begin
      cmd_q    <= pm_wrapper_pkg::cmd_e'({shift_en_i, select_ctr_i});
      serial_q <= serial_in_i;
    end
  end

  // ------------------------------
  // issue and ack
  // ------------------------------
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      taken_q <= 1'b0;
      ack_q   <= 1'b0;
    end else if (!req_sync) begin
      taken_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      if (cmd_bus.cmd_valid) begin
        taken_q <= 1'b1;
      end
      if (cmd_bus.cfg_done || cmd_bus.ctrl_done) begin
        ack_q <= 1'b1;
      end
    end
  end

  // single pulse per request
  assign cmd_bus.cmd_valid  = req_sync & ~ack_q & ~taken_q;
  assign cmd_bus.cmd        = cmd_q;
  assign cmd_bus.serial_bit = serial_q;
  assign pmbw_ack_o         = ack_q;

endmodule

// ==== source/pm_cfg_shift.sv ====
/* serial sensor configuration shift register */
`timescale 1ns/10ps

module pm_cfg_shift (
  input  logic                      rc_osc_i_after_mux,
  input  logic                      pmbw_rstn,
  pm_cmd_if.cfg                     cmd_bus,
  output pm_wrapper_pkg::cfg_word_u cfg_o
);

  localparam int CFG_BITS = pm_wrapper_pkg::CFG_BITS;
  localparam int NUM_PD   = pm_wrapper_pkg::NUM_SENSORS;

  pm_wrapper_pkg::cfg_word_u cfg_q;
  logic                      shift_cfg;
  logic                      cfg_done_q;

  assign shift_cfg = cmd_bus.cmd_valid &&
                     (cmd_bus.cmd == pm_wrapper_pkg::CMD_SHIFT_CFG);

  // ------------------------------
  // shift register
  // ------------------------------
  // first bit in ends up in div_rc msb after a full word
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      // sensors powered down, dividers cleared
      cfg_q.flat <= {{(CFG_BITS-NUM_PD){1'b0}}, {NUM_PD{1'b1}}};
      cfg_done_q <= 1'b0;
    end else begin
      cfg_done_q <= shift_cfg;
      if (shift_cfg) begin
        cfg_q.flat <= {cfg_q.flat[CFG_BITS-2:0], cmd_bus.serial_bit};
      end
    end
  end

  // shift commands complete here, whatever the FSM state
  assign cmd_bus.cfg_done = cfg_done_q;
  assign cfg_o            = cfg_q;

endmodule

// ==== source/pm_ring_counter.sv ====
/* ring sensor clock synchronizer, rising edge detect
   and saturating edge counter with sticky overflow msb */
`timescale 1ns/10ps

module pm_ring_counter #(
  parameter int COUNTER_SIZE = 32
) (
  input  logic                    rc_osc_i_after_mux,
  input  logic                    pmbw_rstn,
  input  logic                    sensor_clk_i,
  input  logic                    idx_count_en_i,
  input  logic                    clear_i,
  output logic                    busy_o,
  output logic [COUNTER_SIZE-1:0] count_o
);

  localparam int DEPTH = pm_wrapper_pkg::SYNC_DEPTH_SENSOR;

  logic [DEPTH-1:0]        sclk_sync_q;
  logic                    sclk_prev_q;
  logic                    sclk_rise;
  logic                    busy_q;
  logic [COUNTER_SIZE-1:0] count_q;

  // ------------------------------
  // sync and edge detect
  // ------------------------------
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      sclk_sync_q <= '0;
      sclk_prev_q <= 1'b0;
      busy_q      <= 1'b0;
    end else begin
      sclk_sync_q <= {sclk_sync_q[DEPTH-2:0], sensor_clk_i};
      sclk_prev_q <= sclk_sync_q[DEPTH-1];
      busy_q      <= idx_count_en_i;
    end
  end

  assign sclk_rise = sclk_sync_q[DEPTH-1] & ~sclk_prev_q;

  // counting follows busy, so the count is frozen once busy is low
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (busy_q && sclk_rise) begin
      if (&count_q[COUNTER_SIZE-2:0]) begin
        count_q[COUNTER_SIZE-1] <= 1'b1;
      end else begin
        count_q[COUNTER_SIZE-2:0] <= count_q[COUNTER_SIZE-2:0] + 1'b1;
      end
    end
  end

  assign busy_o  = busy_q;
  assign count_o = count_q;

endmodule

// ==== source/pm_sensor_ctrl.sv ====
/* wrapper FSM with sensor power and divider control,
   count capture registers and serial count readout */
`timescale 1ns/10ps

module pm_sensor_ctrl #(
  parameter int COUNTER_SIZE = 32
) (
  input  logic                                   rc_osc_i_after_mux,
  input  logic                                   pmbw_rstn,
  input  pm_wrapper_pkg::cfg_word_u              cfg_i,
  pm_cmd_if.ctrl                                 cmd_bus,
  pm_count_if.ctrl                               cnt_bus,
  output logic                                   serial_out_o,
  output logic [pm_wrapper_pkg::NUM_SENSORS-1:0] sensor_pd_o,
  output logic [1:0]                             sensor_div_o,
  output logic [1:0]                             sensor_div_rc_o
);

  localparam int NS    = pm_wrapper_pkg::NUM_SENSORS;
  localparam int IDX_W = $clog2(NS);

  pm_wrapper_pkg::ctrl_state_e state_q;
  logic [NS-1:0]           count_en_q;
  logic [NS-1:0]           pd_q;
  logic [1:0]              div_q;
  logic [1:0]              div_rc_q;
  logic                    clear_q;
  logic                    serial_out_q;
  logic                    ctrl_done_q;
  logic [COUNTER_SIZE-1:0] cap_q [NS];
  logic                    rd_valid;
  logic [IDX_W-1:0]        rd_idx;
  logic                    shift_count;
  logic                    capture;

  // lowest-indexed enabled sensor feeds the readout
  always_comb begin
    rd_valid = 1'b0;
    rd_idx   = '0;
    for (int i = NS-1; i >= 0; i--) begin
      if (!cfg_i.fields.powerdown[i]) begin
        rd_valid = 1'b1;
        rd_idx   = IDX_W'(i);
      end
    end
  end

  assign shift_count = cmd_bus.cmd_valid &&
                       (cmd_bus.cmd == pm_wrapper_pkg::CMD_SHIFT_COUNT);
  // counts are stable once every busy flag has dropped
  assign capture = (state_q == pm_wrapper_pkg::ST_SAVE) && !(|cnt_bus.busy);

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      state_q      <= pm_wrapper_pkg::ST_IDLE;
      count_en_q   <= '0;
      pd_q         <= '1;
      div_q        <= 2'b00;
      div_rc_q     <= 2'b00;
      clear_q      <= 1'b0;
      serial_out_q <= 1'b0;
      ctrl_done_q  <= 1'b0;
    end else begin
      clear_q     <= 1'b0;
      ctrl_done_q <= 1'b0;
      // readout is served in any state
      if (shift_count) begin
        serial_out_q <= rd_valid ? cap_q[rd_idx][COUNTER_SIZE-1] : 1'b0;
        ctrl_done_q  <= 1'b1;
      end
      case (state_q)
        pm_wrapper_pkg::ST_IDLE: begin
          if (cmd_bus.cmd_valid && cmd_bus.cmd == pm_wrapper_pkg::CMD_SELECT) begin
            div_q       <= cfg_i.fields.div;
            div_rc_q    <= cfg_i.fields.div_rc;
            clear_q     <= 1'b1;
            ctrl_done_q <= 1'b1;
            state_q     <= pm_wrapper_pkg::ST_RUN;
          end else if (cmd_bus.cmd_valid &&
                       cmd_bus.cmd == pm_wrapper_pkg::CMD_DESELECT) begin
            pd_q        <= '1;
            clear_q     <= 1'b1;
            ctrl_done_q <= 1'b1;
          end
        end
        pm_wrapper_pkg::ST_RUN: begin
          pd_q       <= cfg_i.fields.powerdown;
          count_en_q <= ~cfg_i.fields.powerdown;
          if (cmd_bus.cmd_valid && cmd_bus.cmd == pm_wrapper_pkg::CMD_DESELECT) begin
            state_q <= pm_wrapper_pkg::ST_SAVE;
          end
        end
        pm_wrapper_pkg::ST_SAVE: begin
          count_en_q <= '0;
          if (capture) begin
            state_q <= pm_wrapper_pkg::ST_STOP;
          end
        end
        pm_wrapper_pkg::ST_STOP: begin
          pd_q        <= '1;
          ctrl_done_q <= 1'b1;
          state_q     <= pm_wrapper_pkg::ST_IDLE;
        end
        default: state_q <= pm_wrapper_pkg::ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // capture and rotate
  // ------------------------------
  always_ff @(posedge rc_osc_i_after_mux) begin
    if (capture) begin
      for (int i = 0; i < NS; i++) begin
        if (!cfg_i.fields.powerdown[i]) begin
          cap_q[i] <= cnt_bus.count[i];
        end
      end
    end else if (shift_count && rd_valid) begin
      // rotate so a second read sees the same value
      cap_q[rd_idx] <= {cap_q[rd_idx][COUNTER_SIZE-2:0], cap_q[rd_idx][COUNTER_SIZE-1]};
    end
  end

  assign cnt_bus.count_en  = count_en_q;
  assign cnt_bus.clear     = clear_q;
  assign cmd_bus.ctrl_done = ctrl_done_q;
  assign serial_out_o      = serial_out_q;
  assign sensor_pd_o       = pd_q;
  assign sensor_div_o      = div_q;
  assign sensor_div_rc_o   = div_rc_q;

endmodule

// ==== source/pm_wrapper_top.sv ====
/* power-monitor sensor wrapper top: request decoder, config shift,
   control FSM and one edge counter per ring sensor */
`timescale 1ns/10ps

module pm_wrapper_top #(
  parameter int COUNTER_SIZE = 32
) (
  input  logic                                   rc_osc_i_after_mux,
  input  logic                                   pmbw_rstn,
  // host req/ack link
  input  logic                                   pmbw_req_i,
  input  logic                                   serial_in_i,
  input  logic                                   shift_en_i,
  input  logic                                   select_ctr_i,
  output logic                                   pmbw_ack_o,
  output logic                                   serial_out_o,
  // ring sensors
  input  logic [pm_wrapper_pkg::NUM_SENSORS-1:0] sensor_clk_i,
  output logic [pm_wrapper_pkg::NUM_SENSORS-1:0] sensor_pd_o,
  output logic [1:0]                             sensor_div_o,
  output logic [1:0]                             sensor_div_rc_o
);

  pm_wrapper_pkg::cfg_word_u cfg_word;

  pm_cmd_if cmd_bus ();

  pm_count_if #(
    .COUNTER_SIZE (COUNTER_SIZE)
  ) cnt_bus ();

  // ------------------------------
  // host side
  // ------------------------------
  pm_req_sync u_req_sync (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .pmbw_req_i         (pmbw_req_i),
    .serial_in_i        (serial_in_i),
    .shift_en_i         (shift_en_i),
    .select_ctr_i       (select_ctr_i),
    .pmbw_ack_o         (pmbw_ack_o),
    .cmd_bus            (cmd_bus.decoder)
  );

  pm_cfg_shift u_cfg_shift (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .cmd_bus            (cmd_bus.cfg),
    .cfg_o              (cfg_word)
  );

  // ------------------------------
  // control and counters
  // ------------------------------
  pm_sensor_ctrl #(
    .COUNTER_SIZE (COUNTER_SIZE)
  ) u_sensor_ctrl (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .cfg_i              (cfg_word),
    .cmd_bus            (cmd_bus.ctrl),
    .cnt_bus            (cnt_bus.ctrl),
    .serial_out_o       (serial_out_o),
    .sensor_pd_o        (sensor_pd_o),
    .sensor_div_o       (sensor_div_o),
    .sensor_div_rc_o    (sensor_div_rc_o)
  );

  // one counter per sensor, each on its own slice of cnt_bus
  for (genvar i = 0; i < pm_wrapper_pkg::NUM_SENSORS; i++) begin : gen_ring_counter
    pm_ring_counter #(
      .COUNTER_SIZE (COUNTER_SIZE)
    ) u_ring_counter (
      .rc_osc_i_after_mux (rc_osc_i_after_mux),
      .pmbw_rstn          (pmbw_rstn),
      .sensor_clk_i       (sensor_clk_i[i]),
      .idx_count_en_i     (cnt_bus.count_en[i]),
      .clear_i            (cnt_bus.clear),
      .busy_o             (cnt_bus.busy[i]),
      .count_o            (cnt_bus.count[i])
    );
  end

endmodule

// ==== verif/pm_wrapper_props.sv ====
/* concurrent checks on command completion, FSM state and sensor power,
   bound into the sensor control block */
`timescale 1ns/10ps

module pm_wrapper_props (
  input logic                                   rc_osc_i_after_mux,
  input logic                                   pmbw_rstn,
  input logic                                   cmd_valid_i,
  input pm_wrapper_pkg::cmd_e                   cmd_i,
  input logic                                   ctrl_done_i,
  input pm_wrapper_pkg::ctrl_state_e            state_i,
  input logic [pm_wrapper_pkg::NUM_SENSORS-1:0] sensor_pd_i
);

  logic pending_q;

  // a control-owned command is outstanding
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      pending_q <= 1'b0;
    end else if (cmd_valid_i && (cmd_i != pm_wrapper_pkg::CMD_SHIFT_CFG)) begin
      pending_q <= 1'b1;
    end else if (ctrl_done_i) begin
      pending_q <= 1'b0;
    end
  end

  // ------------------------------
  // properties
  // ------------------------------
  // done pulses raise the ack, so each needs a request behind it
  a_done_needs_request: assert property (
    @(posedge rc_osc_i_after_mux) disable iff (!pmbw_rstn)
    ctrl_done_i |-> pending_q
  ) else $error("control done pulse without a pending request");

  // stop only follows save, save only follows run or save
  a_state_legal: assert property (
    @(posedge rc_osc_i_after_mux) disable iff (!pmbw_rstn)
    ((state_i != pm_wrapper_pkg::ST_STOP) ||
     ($past(state_i) == pm_wrapper_pkg::ST_SAVE)) &&
    ((state_i != pm_wrapper_pkg::ST_SAVE) ||
     ($past(state_i) == pm_wrapper_pkg::ST_RUN) ||
     ($past(state_i) == pm_wrapper_pkg::ST_SAVE))
  ) else $error("wrapper FSM took an illegal transition");

  a_pd_in_idle: assert property (
    @(posedge rc_osc_i_after_mux) disable iff (!pmbw_rstn)
    (state_i == pm_wrapper_pkg::ST_IDLE) |-> (&sensor_pd_i)
  ) else $error("sensor powered up while the FSM is idle");

endmodule

bind pm_sensor_ctrl pm_wrapper_props u_props (
  .rc_osc_i_after_mux (rc_osc_i_after_mux),
  .pmbw_rstn          (pmbw_rstn),
  .cmd_valid_i        (cmd_bus.cmd_valid),
  .cmd_i              (cmd_bus.cmd),
  .ctrl_done_i        (ctrl_done_q),
  .state_i            (state_q),
  .sensor_pd_i        (sensor_pd_o)
);

// ==== verif/tb_pm_wrapper.sv ====
/* testbench for the power-monitor wrapper with host req/ack tasks,
   sensor pulses, reference count model, compare process and watchdog */
`timescale 1ns/10ps

module tb_pm_wrapper;

  localparam int         COUNTER_SIZE = 8;
  localparam int         NS           = pm_wrapper_pkg::NUM_SENSORS;
  localparam int         CLK_PERIOD   = 40;
  localparam int         NUM_REQUESTS = 53;
  localparam int         ACK_CYCLES   = 40;
  localparam int         WATCHDOG_NS  = NUM_REQUESTS * 40 * CLK_PERIOD + 20000;
  // div_rc 2, div 1, sensors 1 and 3 powered up
  localparam logic [7:0] CFG_RUN      = 8'h95;
  localparam logic [7:0] CFG_OFF      = 8'h0f;

  logic          rc_osc_i_after_mux;
  logic          pmbw_rstn;
  logic          pmbw_req_i;
  logic          serial_in_i;
  logic          shift_en_i;
  logic          select_ctr_i;
  logic [NS-1:0] sensor_clk_i;
  logic          pmbw_ack_o;
  logic          serial_out_o;
  logic [NS-1:0] sensor_pd_o;
  logic [1:0]    sensor_div_o;
  logic [1:0]    sensor_div_rc_o;

  integer                  seed;
  int                      err_value;
  int                      err_proto;
  int                      num_req;
  int                      num_ack;
  logic                    ack_prev;
  logic                    last_serial;
  int                      pulse_n [NS];
  logic [COUNTER_SIZE-1:0] got_q [$];
  logic [COUNTER_SIZE-1:0] exp_q [$];
  event                    result_ev;

  pm_wrapper_top #(
    .COUNTER_SIZE (COUNTER_SIZE)
  ) pm_wrapper_top_inst (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .pmbw_req_i         (pmbw_req_i),
    .serial_in_i        (serial_in_i),
    .shift_en_i         (shift_en_i),
    .select_ctr_i       (select_ctr_i),
    .pmbw_ack_o         (pmbw_ack_o),
    .serial_out_o       (serial_out_o),
    .sensor_clk_i       (sensor_clk_i),
    .sensor_pd_o        (sensor_pd_o),
    .sensor_div_o       (sensor_div_o),
    .sensor_div_rc_o    (sensor_div_rc_o)
  );

  initial begin
    rc_osc_i_after_mux = 1'b0;
    forever #(CLK_PERIOD / 2) rc_osc_i_after_mux = ~rc_osc_i_after_mux;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // saturates at all-ones low bits, msb flags overflow
  function automatic logic [COUNTER_SIZE-1:0] expected_count(input int pulses);
    int max_low;
    max_low = (1 << (COUNTER_SIZE - 1)) - 1;
    if (pulses > max_low) begin
      expected_count = '1;
    end else begin
      expected_count = COUNTER_SIZE'(pulses);
    end
  endfunction

  // readout follows the lowest sensor not powered down
  function automatic logic [COUNTER_SIZE-1:0] expected_readout(input logic [NS-1:0] pd);
    int idx;
    idx = -1;
    for (int i = NS - 1; i >= 0; i--) begin
      if (!pd[i]) idx = i;
    end
    expected_readout = (idx < 0) ? '0 : expected_count(pulse_n[idx]);
  endfunction

  // ------------------------------
  // host and sensor tasks
  // ------------------------------
  task automatic send_request(input logic shift_en, input logic select_ctr, input logic sdata);
    int waited;
    @(posedge rc_osc_i_after_mux);
    #2;
    shift_en_i   = shift_en;
    select_ctr_i = select_ctr;
    serial_in_i  = sdata;
    pmbw_req_i   = 1'b1;
    num_req++;
    waited = 0;
    @(negedge rc_osc_i_after_mux);
    while (pmbw_ack_o !== 1'b1 && waited < ACK_CYCLES) begin
      @(negedge rc_osc_i_after_mux);
      waited++;
    end
    if (pmbw_ack_o !== 1'b1) begin
      $display("request %0d got no ack within %0d cycles", num_req, ACK_CYCLES);
      err_proto++;
    end
    last_serial = serial_out_o;
    @(posedge rc_osc_i_after_mux);
    #2;
    pmbw_req_i = 1'b0;
    waited = 0;
    @(negedge rc_osc_i_after_mux);
    while (pmbw_ack_o !== 1'b0 && waited < ACK_CYCLES) begin
      @(negedge rc_osc_i_after_mux);
      waited++;
    end
    if (pmbw_ack_o !== 1'b0) begin
      $display("ack stayed high after request %0d was dropped", num_req);
      err_proto++;
    end
  endtask

  // msb of the word is shifted first
  task automatic shift_config(input logic [7:0] word);
    for (int b = 7; b >= 0; b--) begin
      send_request(1'b1, 1'b0, word[b]);
    end
  endtask

  task automatic read_and_queue(input logic [COUNTER_SIZE-1:0] expected);
    logic [COUNTER_SIZE-1:0] value;
    for (int b = COUNTER_SIZE - 1; b >= 0; b--) begin
      send_request(1'b1, 1'b1, 1'b0);
      value[b] = last_serial;
    end
    got_q.push_back(value);
    exp_q.push_back(expected);
    -> result_ev;
  endtask

  // 200 ns period, all sensors in parallel
  task automatic pulse_sensors();
    int max_n;
    max_n = 0;
    for (int s = 0; s < NS; s++) begin
      if (pulse_n[s] > max_n) max_n = pulse_n[s];
    end
    @(posedge rc_osc_i_after_mux);
    #2;
    for (int k = 0; k < max_n; k++) begin
      for (int s = 0; s < NS; s++) begin
        sensor_clk_i[s] = (k < pulse_n[s]);
      end
      repeat (3) @(posedge rc_osc_i_after_mux);
      #2;
      sensor_clk_i = '0;
      repeat (2) @(posedge rc_osc_i_after_mux);
      #2;
    end
    repeat (4) @(posedge rc_osc_i_after_mux);
  endtask

  task automatic check_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_value++;
    end
  endtask

  // ------------------------------
  // compare, ack count, watchdog
  // ------------------------------
  initial begin
    logic [COUNTER_SIZE-1:0] got;
    logic [COUNTER_SIZE-1:0] expv;
    forever begin
      @(result_ev);
      while (got_q.size() > 0) begin
        got  = got_q.pop_front();
        expv = exp_q.pop_front();
        if (got !== expv) begin
          $display("FAILED serial_out_o readout: got 0x%0h, expected 0x%0h", got, expv);
          err_value++;
        end
      end
    end
  end

  always @(negedge rc_osc_i_after_mux) begin
    if (pmbw_ack_o === 1'b1 && ack_prev !== 1'b1) num_ack++;
    ack_prev = pmbw_ack_o;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    pmbw_rstn    = 1'b0;
    pmbw_req_i   = 1'b0;
    serial_in_i  = 1'b0;
    shift_en_i   = 1'b0;
    select_ctr_i = 1'b0;
    sensor_clk_i = '0;
    seed         = 73;
    err_value    = 0;
    err_proto    = 0;
    num_req      = 0;
    num_ack      = 0;
    ack_prev     = 1'b0;
    repeat (3) @(posedge rc_osc_i_after_mux);
    #2;
    pmbw_rstn = 1'b1;
    @(negedge rc_osc_i_after_mux);
    check_equal("pmbw_ack_o", pmbw_ack_o, 8'h0);
    check_equal("serial_out_o", serial_out_o, 8'h0);
    check_equal("sensor_div_o", sensor_div_o, 8'h0);
    check_equal("sensor_div_rc_o", sensor_div_rc_o, 8'h0);
    check_equal("sensor_pd_o", sensor_pd_o, 8'hf);

    // config then select
    shift_config(CFG_RUN);
    send_request(1'b0, 1'b1, 1'b0);
    check_equal("sensor_div_o", sensor_div_o, CFG_RUN[5:4]);
    check_equal("sensor_div_rc_o", sensor_div_rc_o, CFG_RUN[7:6]);
    check_equal("sensor_pd_o", sensor_pd_o, CFG_RUN[3:0]);

    // random counts, deselect, read twice
    for (int s = 0; s < NS; s++) begin
      pulse_n[s] = 1 + ({$random(seed)} % 100);
    end
    pulse_sensors();
    send_request(1'b0, 1'b0, 1'b0);
    check_equal("sensor_pd_o", sensor_pd_o, 8'hf);
    read_and_queue(expected_readout(CFG_RUN[NS-1:0]));
    read_and_queue(expected_readout(CFG_RUN[NS-1:0]));

    // past the counter range
    send_request(1'b0, 1'b1, 1'b0);
    for (int s = 0; s < NS; s++) begin
      pulse_n[s] = (1 << (COUNTER_SIZE - 1)) + 2 + ({$random(seed)} % 40);
    end
    pulse_sensors();
    send_request(1'b0, 1'b0, 1'b0);
    read_and_queue(expected_readout(CFG_RUN[NS-1:0]));

    // idle deselect, then all sensors off
    send_request(1'b0, 1'b0, 1'b0);
    check_equal("sensor_pd_o", sensor_pd_o, 8'hf);
    shift_config(CFG_OFF);
    read_and_queue(expected_readout(CFG_OFF[NS-1:0]));

    repeat (4) @(negedge rc_osc_i_after_mux);
    if (num_ack != num_req) begin
      $display("saw %0d acks for %0d requests", num_ack, num_req);
      err_proto++;
    end
    $display("errors: %0d value, %0d protocol", err_value, err_proto);
    if (err_value + err_proto == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== pm_wrapper.f ====
source/pm_wrapper_pkg.sv
source/pm_cmd_if.sv
source/pm_count_if.sv
source/pm_req_sync.sv
source/pm_cfg_shift.sv
source/pm_ring_counter.sv
source/pm_sensor_ctrl.sv
source/pm_wrapper_top.sv
verif/pm_wrapper_props.sv
verif/tb_pm_wrapper.sv
